// ==== hdl/cache_params.svh ====
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// sets per way
`define CACHE_SETS 8

// address fields
`define IDX_W 3
`define TAG_W 24
`define OFS_W 3

// bus widths
`define LINE_W 256
`define WORD_W 32

`endif

// ==== hdl/cache_types_pkg.sv ====
`include "cache_params.svh"

package cache_types_pkg;

    // address fields, {tag, idx, ofs, align} spans 32 bits
    typedef logic [`TAG_W-1:0] tag_t;
    typedef logic [`IDX_W-1:0] idx_t;
    typedef logic [`OFS_W-1:0] ofs_t;
    typedef logic [1:0]        align_t;

    // payload
    typedef logic [`WORD_W-1:0]   word_t;
    typedef logic [`LINE_W-1:0]   line_t;
    typedef logic [`WORD_W/8-1:0] be_t;

endpackage

// ==== hdl/cache_ctrl_pkg.sv ====
package cache_ctrl_pkg;

    typedef enum logic [2:0] {
        s_idle,
        s_check,
        s_writeback,
        s_fill,
        s_resp
    } cache_state_t;

endpackage

// ==== hdl/cache_array.sv ====
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_array #(
    parameter int width = 1
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  write,
    input  cache_types_pkg::idx_t index,
    input  logic [width-1:0]      datain,
    output logic [width-1:0]      dataout
);

    logic [width-1:0] entries [`CACHE_SETS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `CACHE_SETS; i++) begin
                entries[i] <= '0;
            end
        end else if (write) begin
            entries[index] <= datain;
        end
    end

    assign dataout = entries[index];

endmodule

// ==== hdl/word_access.sv ====
`timescale 1ns/1ps

module word_access (
    input  cache_types_pkg::line_t  line,
    input  cache_types_pkg::ofs_t   offset,
    input  cache_types_pkg::align_t alignment,
    input  cache_types_pkg::word_t  wdata,
    input  cache_types_pkg::be_t    byte_enable,
    output cache_types_pkg::word_t  rdata,
    output cache_types_pkg::line_t  merged_line
);

    localparam int WORD_BITS = $bits(cache_types_pkg::word_t);
    localparam int WORD_BYTES = WORD_BITS / 8;

    cache_types_pkg::word_t word_sel;
    cache_types_pkg::word_t word_mod;

    assign word_sel = line[offset*WORD_BITS +: WORD_BITS];

    // misaligned read, zero filled from the top
    assign rdata = word_sel >> {alignment, 3'b000};

    always_comb begin
        int pos;
        word_mod = word_sel;
        for (int k = 0; k < WORD_BYTES; k++) begin
            pos = k + int'(alignment);
            // bytes pushed past the word end are lost
            if (byte_enable[k] && pos < WORD_BYTES) begin
                word_mod[8*pos +: 8] = wdata[8*k +: 8];
            end
        end
    end

    always_comb begin
        merged_line = line;
        merged_line[offset*WORD_BITS +: WORD_BITS] = word_mod;
    end

endmodule

// ==== hdl/cache_datapath.sv ====
`timescale 1ns/1ps

module cache_datapath (
    input  logic                   clk,
    input  logic                   arst_n,
    // processor side
    input  logic [31:0]            mem_address,
    input  cache_types_pkg::word_t mem_wdata,
    input  cache_types_pkg::be_t   mem_byte_enable,
    output cache_types_pkg::word_t mem_rdata,
    // memory side
    output logic [31:0]            pmem_address,
    output cache_types_pkg::line_t pmem_wdata,
    input  cache_types_pkg::line_t pmem_rdata,
    // from control
    input  logic                   way_sel_method,
    input  logic                   load_line_data,
    input  logic                   line_datain_sel,
    input  logic                   load_valid,
    input  logic                   valid_in,
    input  logic                   load_dirty,
    input  logic                   dirty_in,
    input  logic                   load_lru,
    input  logic                   load_wb_reg,
    input  logic                   address_sel,
    // to control
    output logic                   hit,
    output logic                   lru_dirty
);

    localparam int TAG_BITS = $bits(cache_types_pkg::tag_t);
    localparam int LINE_BITS = $bits(cache_types_pkg::line_t);

    cache_types_pkg::tag_t   tag;
    cache_types_pkg::idx_t   idx;
    cache_types_pkg::ofs_t   offset;
    cache_types_pkg::align_t alignment;

    cache_types_pkg::line_t line_out [2];
    cache_types_pkg::tag_t  tag_out [2];
    logic [1:0]             valid_out;
    logic [1:0]             dirty_out;
    logic [1:0]             way_hit;
    logic [1:0]             load_data_way;
    logic [1:0]             load_valid_way;
    logic [1:0]             load_dirty_way;

    logic                   lru_out;
    logic                   way_select;
    cache_types_pkg::line_t selected_line;
    cache_types_pkg::line_t merged_line;
    cache_types_pkg::line_t line_datain;
    cache_types_pkg::line_t wb_line;
    cache_types_pkg::tag_t  wb_tag;

    assign {tag, idx, offset, alignment} = mem_address;

    for (genvar w = 0; w < 2; w++) begin : g_way
        cache_array #(.width(LINE_BITS)) u_data (
            .clk,
            .arst_n,
            .write   (load_data_way[w]),
            .index   (idx),
            .datain  (line_datain),
            .dataout (line_out[w])
        );

        cache_array #(.width(TAG_BITS)) u_tag (
            .clk,
            .arst_n,
            .write   (load_data_way[w]),
            .index   (idx),
            .datain  (tag),
            .dataout (tag_out[w])
        );

        cache_array #(.width(1)) u_valid (
            .clk,
            .arst_n,
            .write   (load_valid_way[w]),
            .index   (idx),
            .datain  (valid_in),
            .dataout (valid_out[w])
        );

        cache_array #(.width(1)) u_dirty (
            .clk,
            .arst_n,
            .write   (load_dirty_way[w]),
            .index   (idx),
            .datain  (dirty_in),
            .dataout (dirty_out[w])
        );

        assign way_hit[w] = valid_out[w] && (tag_out[w] == tag);

        // per-way write enables
        assign load_data_way[w]  = load_line_data && (way_select == w[0]);
        assign load_valid_way[w] = load_valid && (way_select == w[0]);
        assign load_dirty_way[w] = load_dirty && (way_select == w[0]);
    end

    // lru bit points at the way to replace next
    cache_array #(.width(1)) u_lru (
        .clk,
        .arst_n,
        .write   (load_lru),
        .index   (idx),
        .datain  (~way_select),
        .dataout (lru_out)
    );

    assign hit = |way_hit;
    assign lru_dirty = dirty_out[lru_out];
    assign way_select = way_sel_method ? lru_out : way_hit[1];
    assign selected_line = line_out[way_select];

    word_access u_word (
        .line        (selected_line),
        .offset      (offset),
        .alignment   (alignment),
        .wdata       (mem_wdata),
        .byte_enable (mem_byte_enable),
        .rdata       (mem_rdata),
        .merged_line (merged_line)
    );

    assign line_datain = line_datain_sel ? merged_line : pmem_rdata;

    // victim line and its tag, held for the whole write-back
    always_ff @(posedge clk) begin
        if (load_wb_reg) begin
            wb_line <= line_out[lru_out];
            wb_tag  <= tag_out[lru_out];
        end
    end

    assign pmem_wdata = wb_line;
    assign pmem_address = address_sel ? {wb_tag, idx, 5'b0} : {tag, idx, 5'b0};

endmodule

// ==== hdl/cache_control.sv ====
`timescale 1ns/1ps

module cache_control (
    input  logic clk,
    input  logic arst_n,
    // processor side
    input  logic mem_read,
    input  logic mem_write,
    output logic mem_resp,
    // memory side
    output logic pmem_read,
    output logic pmem_write,
    input  logic pmem_resp,
    // datapath status
    input  logic hit,
    input  logic lru_dirty,
    // datapath strobes
    output logic way_sel_method,
    output logic load_line_data,
    output logic line_datain_sel,
    output logic load_valid,
    output logic valid_in,
    output logic load_dirty,
    output logic dirty_in,
    output logic load_lru,
    output logic load_wb_reg,
    output logic address_sel
);

    cache_ctrl_pkg::cache_state_t state;
    cache_ctrl_pkg::cache_state_t state_nxt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= cache_ctrl_pkg::s_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt       = state;
        mem_resp        = 1'b0;
        pmem_read       = 1'b0;
        pmem_write      = 1'b0;
        way_sel_method  = 1'b0;
        load_line_data  = 1'b0;
        line_datain_sel = 1'b0;
        load_valid      = 1'b0;
        valid_in        = 1'b0;
        load_dirty      = 1'b0;
        dirty_in        = 1'b0;
        load_lru        = 1'b0;
        load_wb_reg     = 1'b0;
        address_sel     = 1'b0;

        case (state)
            cache_ctrl_pkg::s_idle: begin
                if (mem_read || mem_write) begin
                    state_nxt = cache_ctrl_pkg::s_check;
                end
            end
            cache_ctrl_pkg::s_check: begin
                if (hit) begin
                    mem_resp = 1'b1;
                    load_lru = 1'b1;
                    if (mem_write) begin
                        load_line_data  = 1'b1;
                        line_datain_sel = 1'b1;
                        load_dirty      = 1'b1;
                        dirty_in        = 1'b1;
                    end
                    state_nxt = cache_ctrl_pkg::s_resp;
                end else if (lru_dirty) begin
                    load_wb_reg = 1'b1;
                    state_nxt   = cache_ctrl_pkg::s_writeback;
                end else begin
                    state_nxt = cache_ctrl_pkg::s_fill;
                end
            end
            cache_ctrl_pkg::s_writeback: begin
                pmem_write  = 1'b1;
                address_sel = 1'b1;
                if (pmem_resp) begin
                    state_nxt = cache_ctrl_pkg::s_fill;
                end
            end
            cache_ctrl_pkg::s_fill: begin
                pmem_read      = 1'b1;
                way_sel_method = 1'b1;
                if (pmem_resp) begin
                    // new line lands clean in the lru way
                    load_line_data = 1'b1;
                    load_valid     = 1'b1;
                    valid_in       = 1'b1;
                    load_dirty     = 1'b1;
                    state_nxt      = cache_ctrl_pkg::s_check;
                end
            end
            cache_ctrl_pkg::s_resp: begin
                // processor drops its request during this cycle
                state_nxt = cache_ctrl_pkg::s_idle;
            end
            default: begin
                state_nxt = cache_ctrl_pkg::s_idle;
            end
        endcase
    end

endmodule

// ==== hdl/cache.sv ====
`timescale 1ns/1ps

module cache (
    input  logic                   clk,
    input  logic                   arst_n,
    // processor side
    input  logic                   mem_read,
    input  logic                   mem_write,
    input  logic [31:0]            mem_address,
    input  cache_types_pkg::word_t mem_wdata,
    input  cache_types_pkg::be_t   mem_byte_enable,
    output cache_types_pkg::word_t mem_rdata,
    output logic                   mem_resp,
    // memory side
    output logic                   pmem_read,
    output logic                   pmem_write,
    output logic [31:0]            pmem_address,
    output cache_types_pkg::line_t pmem_wdata,
    input  cache_types_pkg::line_t pmem_rdata,
    input  logic                   pmem_resp
);

    logic way_sel_method;
    logic load_line_data;
    logic line_datain_sel;
    logic load_valid;
    logic valid_in;
    logic load_dirty;
    logic dirty_in;
    logic load_lru;
    logic load_wb_reg;
    logic address_sel;
    logic hit;
    logic lru_dirty;

    cache_control u_control (
        .clk,
        .arst_n,
        .mem_read,
        .mem_write,
        .mem_resp,
        .pmem_read,
        .pmem_write,
        .pmem_resp,
        .hit,
        .lru_dirty,
        .way_sel_method,
        .load_line_data,
        .line_datain_sel,
        .load_valid,
        .valid_in,
        .load_dirty,
        .dirty_in,
        .load_lru,
        .load_wb_reg,
        .address_sel
    );

    cache_datapath u_datapath (
        .clk,
        .arst_n,
        .mem_address,
        .mem_wdata,
        .mem_byte_enable,
        .mem_rdata,
        .pmem_address,
        .pmem_wdata,
        .pmem_rdata,
        .way_sel_method,
        .load_line_data,
        .line_datain_sel,
        .load_valid,
        .valid_in,
        .load_dirty,
        .dirty_in,
        .load_lru,
        .load_wb_reg,
        .address_sel,
        .hit,
        .lru_dirty
    );

endmodule

// ==== tb/cache_asserts.sv ====
`timescale 1ns/1ps

module cache_asserts (
    input logic                         clk,
    input logic                         arst_n,
    input logic                         mem_read,
    input logic                         mem_write,
    input logic                         mem_resp,
    input logic                         pmem_read,
    input logic                         pmem_write,
    input logic [31:0]                  pmem_address,
    input logic                         pmem_resp,
    input cache_ctrl_pkg::cache_state_t state
);

    int unsigned errors = 0;

    resp_single: assert property (@(posedge clk) disable iff (!arst_n)
        mem_resp |=> !mem_resp)
        else begin
            $error("mem_resp held high for two cycles");
            errors++;
        end

    pmem_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
        !(pmem_read && pmem_write))
        else begin
            $error("pmem_read and pmem_write high together");
            errors++;
        end

    // memory side only ever sees whole lines
    pmem_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        (pmem_read || pmem_write) |-> pmem_address[4:0] == 5'd0)
        else begin
            $error("pmem_address not line aligned");
            errors++;
        end

    resp_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
        mem_resp |-> (mem_read || mem_write))
        else begin
            $error("mem_resp without a request");
            errors++;
        end

    // a finished fill turns into a hit on the next cycle
    fill_then_resp: assert property (@(posedge clk) disable iff (!arst_n)
        (state == cache_ctrl_pkg::s_fill && pmem_resp) |=> mem_resp)
        else begin
            $error("no mem_resp right after a line fill");
            errors++;
        end

endmodule

// ==== tb/cache_tb.sv ====
`timescale 1ns/1ps

module cache_tb;

    logic                   clk;
    logic                   arst_n;
    logic                   mem_read;
    logic                   mem_write;
    logic [31:0]            mem_address;
    cache_types_pkg::word_t mem_wdata;
    cache_types_pkg::be_t   mem_byte_enable;
    cache_types_pkg::word_t mem_rdata;
    logic                   mem_resp;
    logic                   pmem_read;
    logic                   pmem_write;
    logic [31:0]            pmem_address;
    cache_types_pkg::line_t pmem_wdata;
    cache_types_pkg::line_t pmem_rdata;
    logic                   pmem_resp;

    logic [31:0] stim_rng = 32'h217e;
    logic [31:0] mem_rng = 32'h217e;

    // backing store keyed by line number
    cache_types_pkg::line_t mem_lines [logic [26:0]];
    // shadow keyed by byte address
    logic [7:0]             shadow [logic [31:0]];
    int                     rd_count = 0;
    int                     wr_count = 0;
    logic [31:0]            last_wr_addr;
    cache_types_pkg::line_t last_wr_line;

    cache dut0 (.*);

    bind cache cache_asserts u_asserts (
        .clk,
        .arst_n,
        .mem_read,
        .mem_write,
        .mem_resp,
        .pmem_read,
        .pmem_write,
        .pmem_address,
        .pmem_resp,
        .state (u_control.state)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_stim();
        stim_rng = xorshift(stim_rng);
        return stim_rng;
    endfunction

    function automatic logic [31:0] addr_of(input logic [23:0] tag, input logic [2:0] idx,
                                            input logic [2:0] word, input logic [1:0] align);
        return {tag, idx, word, align};
    endfunction

    function automatic logic [31:0] pattern_word(input logic [31:0] a);
        return {a[31:2], 2'b00} * 32'h9e37_79b1 + 32'h0bad_f00d;
    endfunction

    function automatic logic [7:0] shadow_byte(input logic [31:0] a);
        logic [31:0] w;
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        w = pattern_word(a);
        return w[8*a[1:0] +: 8];
    endfunction

    function automatic cache_types_pkg::line_t shadow_line(input logic [31:0] base);
        cache_types_pkg::line_t l;
        for (int i = 0; i < 32; i++) begin
            l[8*i +: 8] = shadow_byte(base + 32'(i));
        end
        return l;
    endfunction

    function automatic cache_types_pkg::line_t read_line(input logic [31:0] base);
        cache_types_pkg::line_t l;
        if (mem_lines.exists(base[31:5])) begin
            return mem_lines[base[31:5]];
        end
        for (int i = 0; i < 8; i++) begin
            l[32*i +: 32] = pattern_word(base + 32'(4*i));
        end
        return l;
    endfunction

    // aligned word shifted down and zero filled
    function automatic cache_types_pkg::word_t read_expected(input logic [31:0] a);
        logic [31:0] base;
        cache_types_pkg::word_t w;
        base = {a[31:2], 2'b00};
        for (int k = 0; k < 4; k++) begin
            w[8*k +: 8] = shadow_byte(base + 32'(k));
        end
        return w >> {a[1:0], 3'b000};
    endfunction

    function automatic void shadow_write(input logic [31:0] a, input cache_types_pkg::word_t d,
                                         input cache_types_pkg::be_t be);
        logic [31:0] base;
        base = {a[31:2], 2'b00};
        for (int k = 0; k < 4; k++) begin
            if (be[k] && k + int'(a[1:0]) < 4) begin
                shadow[base + 32'(k) + 32'(a[1:0])] = d[8*k +: 8];
            end
        end
    endfunction

    task automatic expect_equal(input string name, input logic [255:0] exp,
                                input logic [255:0] act);
        assert (act === exp) else begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            $display("TEST FAIL");
            $fatal(1, "value mismatch in %s", name);
        end
    endtask

    task automatic timeout_abort(input string what);
        $display("TEST FAIL");
        $fatal(1, "timed out waiting for %s", what);
    endtask

    // one processor request issued on a falling edge
    task automatic access(input string name, input logic wr, input logic [31:0] addr,
                          input cache_types_pkg::word_t wdata, input cache_types_pkg::be_t be);
        int cycles;
        cache_types_pkg::word_t expected;
        expected = read_expected(addr);
        mem_read = ~wr;
        mem_write = wr;
        mem_address = addr;
        mem_wdata = wdata;
        mem_byte_enable = be;
        cycles = 0;
        while (!mem_resp) begin
            if (cycles == 100) begin
                timeout_abort({"mem_resp in ", name});
            end
            cycles++;
            @(negedge clk);
        end
        if (!wr) begin
            expect_equal(name, 256'(expected), 256'(mem_rdata));
        end
        @(negedge clk);
        mem_read = 1'b0;
        mem_write = 1'b0;
        if (wr) begin
            shadow_write(addr, wdata, be);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // protocol assertion failures end the run at once
    always @(negedge clk) begin
        if (dut0.u_asserts.errors != 0) begin
            $display("TEST FAIL");
            $fatal(1, "%0d protocol assertion failures", dut0.u_asserts.errors);
        end
    end

    // line memory with a random 1 to 4 cycle answer
    initial begin
        int delay;
        pmem_resp = 1'b0;
        pmem_rdata = '0;
        forever begin
            @(negedge clk);
            pmem_resp = 1'b0;
            if (arst_n && (pmem_read || pmem_write)) begin
                mem_rng = xorshift(mem_rng);
                delay = int'(mem_rng % 4);
                repeat (delay) @(negedge clk);
                if (pmem_read) begin
                    pmem_rdata = read_line(pmem_address);
                    rd_count++;
                end else begin
                    mem_lines[pmem_address[31:5]] = pmem_wdata;
                    last_wr_addr = pmem_address;
                    last_wr_line = pmem_wdata;
                    wr_count++;
                end
                pmem_resp = 1'b1;
            end
        end
    end

    initial begin
        logic [31:0] r;
        logic [31:0] a;
        logic [2:0]  set;
        int          rd0;
        int          wr0;
        arst_n = 1'b0;
        mem_read = 1'b0;
        mem_write = 1'b0;
        mem_address = '0;
        mem_wdata = '0;
        mem_byte_enable = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        expect_equal("reset_idle", 256'(0), 256'({mem_resp, pmem_read, pmem_write}));

        // read miss then a hit on the same line
        a = addr_of(24'h0000a1, 3'd1, 3'd3, 2'd0);
        rd0 = rd_count;
        access("read_miss", 1'b0, a, '0, '0);
        expect_equal("read_miss_fetch", 256'(rd0 + 1), 256'(rd_count));
        access("read_hit", 1'b0, a, '0, '0);
        expect_equal("read_hit_no_fetch", 256'(rd0 + 1), 256'(rd_count));

        // byte enabled writes checked by aligned reads
        for (int i = 0; i < 8; i++) begin
            r = next_stim();
            a = addr_of(24'h0000a2, 3'd2, r[4:2], r[1:0]);
            access("write_merge", 1'b1, a, next_stim(), r[8:5]);
            access("write_merge_read", 1'b0, {a[31:2], 2'b00}, '0, '0);
        end
        for (int al = 1; al < 4; al++) begin
            access("misaligned_read", 1'b0, addr_of(24'h0000a2, 3'd2, 3'd5, 2'(al)), '0, '0);
        end

        // lru replacement in set 3
        access("lru_a", 1'b0, addr_of(24'h000100, 3'd3, 3'd0, 2'd0), '0, '0);
        access("lru_b", 1'b0, addr_of(24'h000200, 3'd3, 3'd1, 2'd0), '0, '0);
        access("lru_a_again", 1'b0, addr_of(24'h000100, 3'd3, 3'd2, 2'd0), '0, '0);
        access("lru_c", 1'b0, addr_of(24'h000300, 3'd3, 3'd3, 2'd0), '0, '0);
        rd0 = rd_count;
        wr0 = wr_count;
        access("lru_a_kept", 1'b0, addr_of(24'h000100, 3'd3, 3'd4, 2'd0), '0, '0);
        expect_equal("lru_a_no_read", 256'(rd0), 256'(rd_count));
        expect_equal("lru_a_no_write", 256'(wr0), 256'(wr_count));
        access("lru_b_evicted", 1'b0, addr_of(24'h000200, 3'd3, 3'd5, 2'd0), '0, '0);
        expect_equal("lru_b_refetch", 256'(rd0 + 1), 256'(rd_count));

        // dirty eviction writes back but clean eviction does not
        access("dirty_a", 1'b1, addr_of(24'h000400, 3'd4, 3'd6, 2'd0), 32'hc0de_0004, 4'hf);
        access("clean_b", 1'b0, addr_of(24'h000500, 3'd4, 3'd0, 2'd0), '0, '0);
        wr0 = wr_count;
        access("evict_a", 1'b0, addr_of(24'h000600, 3'd4, 3'd1, 2'd0), '0, '0);
        expect_equal("writeback_count", 256'(wr0 + 1), 256'(wr_count));
        a = addr_of(24'h000400, 3'd4, 3'd0, 2'd0);
        expect_equal("writeback_addr", 256'(a), 256'(last_wr_addr));
        expect_equal("writeback_data", shadow_line(a), last_wr_line);
        wr0 = wr_count;
        access("evict_b", 1'b0, addr_of(24'h000700, 3'd4, 3'd2, 2'd0), '0, '0);
        expect_equal("clean_evict_no_write", 256'(wr0), 256'(wr_count));

        // random traffic over sets 5 to 7 and four tags
        for (int i = 0; i < 200; i++) begin
            r = next_stim();
            set = 3'd5 + 3'(r[15:8] % 3);
            a = addr_of(24'h000c00 + 24'(r[17:16]), set, r[4:2], r[1:0]);
            if (r[20]) begin
                access("random_write", 1'b1, a, next_stim(), r[24:21]);
            end else begin
                access("random_read", 1'b0, a, '0, '0);
            end
        end

        @(negedge clk);
        if (dut0.u_asserts.errors != 0) begin
            $display("TEST FAIL");
            $fatal(1, "%0d protocol assertion failures", dut0.u_asserts.errors);
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

// ==== src.f ====
+incdir+hdl
hdl/cache_types_pkg.sv
hdl/cache_ctrl_pkg.sv
hdl/cache_array.sv
hdl/word_access.sv
hdl/cache_datapath.sv
hdl/cache_control.sv
hdl/cache.sv
tb/cache_asserts.sv
tb/cache_tb.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "make test   build the cache testbench with Verilator and run it"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module cache_tb -f src.f
	./obj_dir/Vcache_tb +verilator+error+limit+100

clean:
	rm -rf obj_dir
